// File: design/adc_capture_cfg.svh
`ifndef ADC_CAPTURE_CFG_SVH
`define ADC_CAPTURE_CFG_SVH

// sample path
`define ADC_WIDTH    12
`define DS_WIDTH     13   // downsample ratio field

// capture fifo, FIFO_AW is log2 of FIFO_DEPTH
`define FIFO_DEPTH   16
`define FIFO_AW      4

// consumer slots, credits after reset
`define CREDIT_INIT  4
`define CREDIT_WIDTH 3

// trigger offset and sample counters
`define COUNT_WIDTH  32

`endif

// File: design/adc_capture_pkg.sv
`default_nettype none
`include "adc_capture_cfg.svh"

package adc_capture_pkg;

   typedef logic [`ADC_WIDTH-1:0]    sample_t;   // one adc sample
   typedef logic [`COUNT_WIDTH-1:0]  count_t;    // trigger offset, sample counts
   typedef logic [`DS_WIDTH-1:0]     ds_t;       // keep one sample in ds+1
   typedef logic [`FIFO_AW-1:0]      ptr_t;
   typedef logic [`FIFO_AW:0]        level_t;    // fifo fill, 0 up to FIFO_DEPTH
   typedef logic [`CREDIT_WIDTH-1:0] credit_t;

   // static setup, held while armed
   typedef struct packed {
      logic    source_adc;    // 1 adc, 0 test counter
      ds_t     downsample;
      logic    trig_source;   // 0 external, 1 adc level
      logic    trig_high;     // rising edge / level reached
      logic    trig_wait;     // wait for inactive trigger before arming
      sample_t trig_level;
      count_t  trig_offset;
      count_t  max_samples;
   } capture_cfg_t;

   typedef struct packed {
      logic    valid;
      sample_t sample;
   } cond_sample_t;

   typedef struct packed {
      logic    last;          // final word of the capture
      sample_t sample;
   } out_word_t;

   typedef enum logic [2:0] {
      IDLE,
      WAIT_INACTIVE,
      ARMED,
      OFFSET,
      CAPTURE
   } trig_state_e;

endpackage

`default_nettype wire

// File: design/sample_conditioner.sv
`default_nettype none
`timescale 1ns/1ns

module sample_conditioner
   import adc_capture_pkg::*;
(
   input  wire logic    ADC_clk_sample,
   input  wire logic    reset,
   input  wire sample_t adc_data_i,
   input  wire logic    source_adc_i,
   input  wire ds_t     downsample_i,
   output cond_sample_t sample_o
);

   sample_t test_cnt;   // free-running test pattern
   ds_t     ds_cnt;
   sample_t sample_q;
   logic    valid_q;

   // control state
   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         test_cnt <= '0;
         ds_cnt   <= '0;
         valid_q  <= 1'b0;
      end else begin
         test_cnt <= test_cnt + 1'b1;
         valid_q  <= (ds_cnt == '0);   // first sample of each group is kept
         if (ds_cnt >= downsample_i)
            ds_cnt <= '0;
         else
            ds_cnt <= ds_cnt + 1'b1;
      end
   end

   // payload register, one cycle behind adc_data_i
   always_ff @(posedge ADC_clk_sample) begin
      sample_q <= source_adc_i ? adc_data_i : test_cnt;
   end

   assign sample_o = '{valid: valid_q, sample: sample_q};

endmodule

`default_nettype wire

// File: design/trigger_unit.sv
`default_nettype none
`timescale 1ns/1ns

module trigger_unit
   import adc_capture_pkg::*;
(
   input  wire logic         ADC_clk_sample,
   input  wire logic         reset,
   input  wire capture_cfg_t cfg_i,
   input  wire cond_sample_t sample_i,
   input  wire logic         ext_trigger_i,
   input  wire logic         arm_i,
   input  wire logic         trigger_now_i,
   input  wire logic         capture_done_i,
   output logic              armed_o,
   output logic              capture_go_o
);

   trig_state_e state;
   count_t      offset_cnt;

   logic ext_q;        // registered external trigger
   logic ext_qq;       // previous value, for edge detection
   logic adc_active;
   logic ext_active;
   logic ext_prev_active;
   logic trig_active;
   logic trig_hit;

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         ext_q  <= 1'b0;
         ext_qq <= 1'b0;
      end else begin
         ext_q  <= ext_trigger_i;
         ext_qq <= ext_q;
      end
   end

   // polarity applied to both sources
   always_comb begin
      if (cfg_i.trig_high) begin
         adc_active      = (sample_i.sample >= cfg_i.trig_level);
         ext_active      = ext_q;
         ext_prev_active = ext_qq;
      end else begin
         adc_active      = (sample_i.sample <= cfg_i.trig_level);
         ext_active      = ~ext_q;
         ext_prev_active = ~ext_qq;
      end

      if (cfg_i.trig_source) begin
         trig_active = adc_active;
         trig_hit    = sample_i.valid & adc_active;   // only kept samples count
      end else begin
         trig_active = ext_active;
         trig_hit    = ext_active & ~ext_prev_active;   // edge of chosen polarity
      end
   end

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         state      <= IDLE;
         offset_cnt <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (arm_i) begin
                  if (cfg_i.trig_wait && trig_active)
                     state <= WAIT_INACTIVE;
                  else
                     state <= ARMED;
               end
            end
            WAIT_INACTIVE: begin
               if (!trig_active)
                  state <= ARMED;
            end
            ARMED: begin
               if (trig_hit || trigger_now_i) begin
                  offset_cnt <= cfg_i.trig_offset - 1'b1;
                  if (cfg_i.trig_offset == '0)
                     state <= CAPTURE;
                  else
                     state <= OFFSET;
               end
            end
            OFFSET: begin
               // one cycle per offset count
               offset_cnt <= offset_cnt - 1'b1;
               if (offset_cnt == '0)
                  state <= CAPTURE;
            end
            CAPTURE: begin
               if (capture_done_i)
                  state <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   // armed until the capture itself starts
   assign armed_o      = (state == ARMED) || (state == OFFSET);
   assign capture_go_o = (state == CAPTURE);

endmodule

`default_nettype wire

// File: design/capture_buffer.sv
`default_nettype none
`timescale 1ns/1ns
`include "adc_capture_cfg.svh"

module capture_buffer
   import adc_capture_pkg::*;
(
   input  wire logic         ADC_clk_sample,
   input  wire logic         reset,
   input  wire cond_sample_t sample_i,
   input  wire logic         capture_go_i,
   input  wire count_t       max_samples_i,
   input  wire logic         arm_i,
   input  wire logic         credit_i,
   output logic              capture_done_o,
   output logic              out_valid_o,
   output out_word_t         out_word_o,
   output logic              overflow_o
);

   localparam level_t  LEVEL_FULL = level_t'(`FIFO_DEPTH);
   localparam credit_t CREDIT_RST = credit_t'(`CREDIT_INIT);

   out_word_t mem [`FIFO_DEPTH];

   ptr_t    wr_ptr;
   ptr_t    rd_ptr;
   level_t  level;
   credit_t credits;
   count_t  smp_cnt;
   count_t  smp_nxt;

   logic take;      // valid sample during a capture
   logic is_last;
   logic full;
   logic empty;
   logic push;
   logic pop;

   assign smp_nxt = smp_cnt + 1'b1;
   assign take    = capture_go_i & sample_i.valid;
   assign is_last = take && (smp_nxt == max_samples_i);
   assign full    = (level == LEVEL_FULL);
   assign empty   = (level == '0);
   assign push    = take & ~full;                 // full fifo drops the sample
   assign pop     = (credits != '0) & ~empty;

   assign capture_done_o = is_last;

   // dropped samples still advance the count
   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         smp_cnt <= '0;
      end else if (arm_i || is_last) begin
         smp_cnt <= '0;
      end else if (take) begin
         smp_cnt <= smp_nxt;
      end
   end

   always_ff @(posedge ADC_clk_sample) begin
      if (reset)
         overflow_o <= 1'b0;
      else if (arm_i)
         overflow_o <= 1'b0;
      else if (take && full)
         overflow_o <= 1'b1;   // sticky until the next arm
   end

   always_ff @(posedge ADC_clk_sample) begin
      if (push)
         mem[wr_ptr] <= '{last: is_last, sample: sample_i.sample};
   end

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;
         endcase
      end
   end

   // one credit per word sent, one back per consumer pulse
   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         credits <= CREDIT_RST;
      end else begin
         case ({pop, credit_i})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   always_ff @(posedge ADC_clk_sample) begin
      if (reset)
         out_valid_o <= 1'b0;
      else
         out_valid_o <= pop;
   end

   always_ff @(posedge ADC_clk_sample) begin
      if (pop)
         out_word_o <= mem[rd_ptr];   // word held until the next pop
   end

endmodule

`default_nettype wire

// File: design/adc_capture_top.sv
`default_nettype none
`timescale 1ns/1ns

module adc_capture_top
   import adc_capture_pkg::*;
(
   input  wire logic         ADC_clk_sample,
   input  wire logic         reset,
   input  wire capture_cfg_t cfg_i,
   input  wire logic         arm_i,
   input  wire logic         trigger_now_i,
   input  wire logic         ext_trigger_i,
   input  wire sample_t      adc_data_i,
   input  wire logic         credit_i,
   output logic              armed_o,
   output logic              capture_active_o,   // also the capture_go to the buffer
   output logic              out_valid_o,
   output out_word_t         out_word_o,
   output logic              overflow_o
);

   cond_sample_t cond_sample;
   logic         capture_done;

   sample_conditioner u_conditioner (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .adc_data_i     (adc_data_i),
      .source_adc_i   (cfg_i.source_adc),
      .downsample_i   (cfg_i.downsample),
      .sample_o       (cond_sample)
   );

   trigger_unit u_trigger (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .cfg_i          (cfg_i),
      .sample_i       (cond_sample),
      .ext_trigger_i  (ext_trigger_i),
      .arm_i          (arm_i),
      .trigger_now_i  (trigger_now_i),
      .capture_done_i (capture_done),
      .armed_o        (armed_o),
      .capture_go_o   (capture_active_o)
   );

   capture_buffer u_buffer (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .sample_i       (cond_sample),
      .capture_go_i   (capture_active_o),
      .max_samples_i  (cfg_i.max_samples),
      .arm_i          (arm_i),
      .credit_i       (credit_i),
      .capture_done_o (capture_done),
      .out_valid_o    (out_valid_o),
      .out_word_o     (out_word_o),
      .overflow_o     (overflow_o)
   );

endmodule

`default_nettype wire

// File: tests/tb_adc_capture.sv
`default_nettype none
`timescale 1ns/1ns
`include "adc_capture_cfg.svh"

module tb_adc_capture
   import adc_capture_pkg::*;
;

   localparam int STIM_RAMP  = 0;
   localparam int STIM_STEP  = 1;
   localparam int POL_NOW    = 0;   // credit back as soon as a word is outstanding
   localparam int POL_RANDOM = 1;
   localparam int POL_HOLD   = 2;   // no credits until the capture has ended
   localparam int TIMEOUT    = 6000;

   typedef struct {
      string name;
      bit    source_adc;
      int    downsample;
      bit    trig_source;
      bit    trig_high;
      bit    trig_wait;
      int    level;
      int    offset;
      int    max_samples;
      int    stim;
      bit    use_now;
      int    policy;
      int    exp_count;
      int    exp_delta;
      bit    exp_ovf;
   } row_t;

   logic         ADC_clk_sample;
   logic         reset;
   capture_cfg_t cfg_i;
   logic         arm_i;
   logic         trigger_now_i;
   logic         ext_trigger_i;
   sample_t      adc_data_i;
   logic         credit_i;
   logic         armed_o;
   logic         capture_active_o;
   logic         out_valid_o;
   out_word_t    out_word_o;
   logic         overflow_o;

   row_t      rows[$];
   out_word_t words[$];
   int        rx_total;
   int        credits_total;
   int        errors;
   int        failed_tests;
   int        seed;
   int        wait_cnt;
   int        policy_q;
   bit        hold_credits;
   int        adc_mode;   // 0 hold at zero, 1 ramp, 2 step high

   adc_capture_top u_dut (
      .ADC_clk_sample   (ADC_clk_sample),
      .reset            (reset),
      .cfg_i            (cfg_i),
      .arm_i            (arm_i),
      .trigger_now_i    (trigger_now_i),
      .ext_trigger_i    (ext_trigger_i),
      .adc_data_i       (adc_data_i),
      .credit_i         (credit_i),
      .armed_o          (armed_o),
      .capture_active_o (capture_active_o),
      .out_valid_o      (out_valid_o),
      .out_word_o       (out_word_o),
      .overflow_o       (overflow_o)
   );

   always #2 ADC_clk_sample = ~ADC_clk_sample;

   always @(posedge ADC_clk_sample) begin
      if (adc_mode == 1)
         adc_data_i <= adc_data_i + 1'b1;
      else if (adc_mode == 2)
         adc_data_i <= 12'hC00;
      else
         adc_data_i <= '0;
   end

   // consumer credit returns
   always @(posedge ADC_clk_sample) begin
      credit_i <= 1'b0;
      if (!reset && !hold_credits && (rx_total - credits_total > 0)) begin
         if (policy_q == POL_RANDOM && wait_cnt != 0) begin
            wait_cnt <= wait_cnt - 1;
         end else begin
            credit_i      <= 1'b1;
            credits_total <= credits_total + 1;
            if (policy_q == POL_RANDOM)
               wait_cnt <= $random(seed) & 32'h7;
         end
      end
   end

   // consumer word intake sampled away from the driving edge
   always @(negedge ADC_clk_sample) begin
      if (out_valid_o) begin
         words.push_back(out_word_o);
         rx_total = rx_total + 1;
      end
      assert (rx_total - credits_total <= `CREDIT_INIT) else begin
         $display("more than %0d words outstanding at the consumer", `CREDIT_INIT);
         errors = errors + 1;
      end
   end

   task automatic add_row(input string name, input bit src, input int ds, input bit tsrc,
                          input bit thigh, input bit twait, input int level, input int offset,
                          input int max_s, input int stim, input bit now, input int policy,
                          input int exp_count, input int exp_delta, input bit exp_ovf);
      row_t r;
      r = '{name, src, ds, tsrc, thigh, twait, level, offset, max_s, stim, now, policy,
            exp_count, exp_delta, exp_ovf};
      rows.push_back(r);
   endtask

   task automatic report_timeout(input string what, input string name);
      $display("%s: timed out waiting for %s", name, what);
      errors = errors + 1;
   endtask

   task automatic wait_level(input string what, input string name, input bit want_active,
                             input int limit);
      int n;
      n = 0;
      do begin
         @(negedge ADC_clk_sample);
         n = n + 1;
      end while (capture_active_o != want_active && n < limit);
      if (capture_active_o != want_active)
         report_timeout(what, name);
   endtask

   task automatic run_row(input row_t r);
      int        errs_before;
      int        base;
      int        cr_start;
      int        cr_capture;
      int        count;
      int        n;
      int        idle;
      sample_t   diff;
      out_word_t w;
      errs_before = errors;
      @(posedge ADC_clk_sample);
      cfg_i.source_adc  <= r.source_adc;
      cfg_i.downsample  <= ds_t'(r.downsample);
      cfg_i.trig_source <= r.trig_source;
      cfg_i.trig_high   <= r.trig_high;
      cfg_i.trig_wait   <= r.trig_wait;
      cfg_i.trig_level  <= sample_t'(r.level);
      cfg_i.trig_offset <= count_t'(r.offset);
      cfg_i.max_samples <= count_t'(r.max_samples);
      adc_mode          <= 0;
      policy_q          <= r.policy;
      hold_credits      <= (r.policy == POL_HOLD);
      ext_trigger_i     <= r.trig_wait;   // held high at arm for the wait test
      repeat (3) @(posedge ADC_clk_sample);
      base = rx_total;
      arm_i    <= 1'b1;
      adc_mode <= (r.stim == STIM_RAMP) ? 1 : 2;
      @(posedge ADC_clk_sample);
      arm_i <= 1'b0;
      @(negedge ADC_clk_sample);
      assert (overflow_o == 1'b0) else begin
         $display("ERR %s overflow_o after arm expected 0 actual %0b", r.name, overflow_o);
         errors = errors + 1;
      end
      // one cycle after arm, unless the held trigger must go inactive first
      assert (armed_o == !r.trig_wait) else begin
         $display("ERR %s armed_o after arm expected %0b actual %0b", r.name, !r.trig_wait,
                  armed_o);
         errors = errors + 1;
      end
      if (r.trig_wait) begin
         for (n = 0; n < 30; n++) begin
            @(negedge ADC_clk_sample);
            assert (!capture_active_o && !armed_o) else begin
               $display("%s: armed or capturing while the trigger is still held", r.name);
               errors = errors + 1;
            end
         end
         @(posedge ADC_clk_sample);
         ext_trigger_i <= 1'b0;
         repeat (4) @(posedge ADC_clk_sample);
         ext_trigger_i <= 1'b1;
      end
      if (r.use_now) begin
         n = 0;
         while (!armed_o && n < 20) begin
            @(negedge ADC_clk_sample);
            n = n + 1;
         end
         if (!armed_o)
            report_timeout("armed_o", r.name);
         @(posedge ADC_clk_sample);
         trigger_now_i <= 1'b1;
         @(posedge ADC_clk_sample);
         trigger_now_i <= 1'b0;
      end
      cr_start = credits_total;
      wait_level("capture start", r.name, 1'b1, TIMEOUT);
      assert (!armed_o) else begin
         $display("%s: armed_o still high after the capture started", r.name);
         errors = errors + 1;
      end
      wait_level("capture end", r.name, 1'b0, TIMEOUT);
      cr_capture = credits_total - cr_start;
      assert (overflow_o == r.exp_ovf) else begin
         $display("ERR %s overflow_o expected %0b actual %0b", r.name, r.exp_ovf, overflow_o);
         errors = errors + 1;
      end
      @(posedge ADC_clk_sample);
      hold_credits <= 1'b0;
      // drain until the output stays quiet
      n    = 0;
      idle = 0;
      while (idle < 12 && n < 400) begin
         @(negedge ADC_clk_sample);
         idle = out_valid_o ? 0 : idle + 1;
         n    = n + 1;
      end
      if (idle < 12)
         report_timeout("the output to drain", r.name);
      count = rx_total - base;
      if (r.exp_ovf) begin
         assert (count <= `FIFO_DEPTH + `CREDIT_INIT + cr_capture && count < r.max_samples)
         else begin
            $display("ERR %s word count expected at most %0d actual %0d", r.name,
                     `FIFO_DEPTH + `CREDIT_INIT + cr_capture, count);
            errors = errors + 1;
         end
      end else begin
         assert (count == r.exp_count) else begin
            $display("ERR %s word count expected %0d actual %0d", r.name, r.exp_count, count);
            errors = errors + 1;
         end
         for (n = 0; n < count; n++) begin
            w = words[base + n];
            assert (w.last == (n == count - 1)) else begin
               $display("ERR %s last on word %0d expected %0b actual %0b", r.name, n,
                        (n == count - 1), w.last);
               errors = errors + 1;
            end
            if (n > 0) begin
               diff = w.sample - words[base + n - 1].sample;
               assert (diff == sample_t'(r.exp_delta)) else begin
                  $display("ERR %s step at word %0d expected %0d actual %0d", r.name, n,
                           r.exp_delta, diff);
                  errors = errors + 1;
               end
            end
         end
         if (r.trig_source && count > 0) begin
            assert (words[base].sample >= sample_t'(r.level)) else begin
               $display("ERR %s first sample expected >= %0h actual %0h", r.name, r.level,
                        words[base].sample);
               errors = errors + 1;
            end
         end
      end
      if (errors == errs_before) begin
         $display("test %s: ok, %0d words", r.name, count);
      end else begin
         $display("test %s: failed with %0d errors", r.name, errors - errs_before);
         failed_tests = failed_tests + 1;
      end
   endtask

   initial begin
      ADC_clk_sample = 1'b0;
      reset          = 1'b1;
      cfg_i          = '0;
      arm_i          = 1'b0;
      trigger_now_i  = 1'b0;
      ext_trigger_i  = 1'b0;
      adc_data_i     = '0;
      credit_i       = 1'b0;
      rx_total       = 0;
      credits_total  = 0;
      errors         = 0;
      failed_tests   = 0;
      seed           = 7486;
      wait_cnt       = 0;
      policy_q       = POL_NOW;
      hold_credits   = 1'b0;
      adc_mode       = 0;

      //      name          src ds tsrc hi wait level offs max stim       now pol      cnt d ovf
      add_row("counter_now",  0, 0, 0, 1, 0, 0,     0,  10, STIM_STEP, 1, POL_NOW,    10, 1, 0);
      add_row("downsample_3", 0, 3, 0, 1, 0, 0,     5,   8, STIM_STEP, 1, POL_NOW,     8, 4, 0);
      add_row("adc_level",    1, 0, 1, 1, 0, 'h800, 0,  10, STIM_RAMP, 0, POL_NOW,    10, 1, 0);
      add_row("ext_wait",     0, 0, 0, 1, 1, 0,     0,   6, STIM_STEP, 0, POL_NOW,     6, 1, 0);
      add_row("backpressure", 0, 0, 0, 1, 0, 0,     0,  40, STIM_STEP, 1, POL_HOLD,    0, 1, 1);
      add_row("credit_rand",  0, 0, 0, 1, 0, 0,     2,  12, STIM_STEP, 1, POL_RANDOM, 12, 1, 0);

      repeat (4) @(posedge ADC_clk_sample);
      reset <= 1'b0;
      @(negedge ADC_clk_sample);
      assert (!armed_o && !capture_active_o && !out_valid_o && !overflow_o) else begin
         $display("outputs not low after reset");
         errors = errors + 1;
      end

      foreach (rows[i])
         run_row(rows[i]);

      $display("tests %0d, failed %0d, errors %0d", rows.size(), failed_tests, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
+incdir+design
design/adc_capture_pkg.sv
design/sample_conditioner.sv
design/trigger_unit.sv
design/capture_buffer.sv
design/adc_capture_top.sv
tests/tb_adc_capture.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the capture front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --timing -f project.f --top-module tb_adc_capture \
   -Mdir obj_dir > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_adc_capture > sim.log 2>&1
cat sim.log

grep -q "^Done: no errors$" sim.log && echo "simulation passed" || {
   echo "simulation failed"
   exit 1
}
